// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_video
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+rtl
rtl/video_pkg.sv
rtl/bus_pkg.sv
rtl/video_if.sv
rtl/video_cen.sv
rtl/video_timing.sv
rtl/tile_gfx.sv
rtl/video_colmix.sv
rtl/video_top.sv
tb/tb_clk.sv
tb/tb_video.sv

// File: rtl/bus_pkg.sv
package bus_pkg;

    // decoded cpu regions
    typedef enum logic [1:0] {
        REG_NONE,
        REG_VRAM,
        REG_PAL,
        REG_CTRL
    } region_e;

    // control register contents
    typedef struct packed {
        logic irq_en;
    } ctrl_t;

endpackage

// File: rtl/tile_gfx.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module tile_gfx import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic [8:0] hdump,
    input  logic [8:0] vdump,
    cpu_bus_if.target  bus,
    rom_if.requester   rom,
    output pxl_t       pxl,
    output bank_t      bank
);

    logic [7:0]            vram [0:(1 << `VRAM_AW) - 1];
    fetch_state_e          state;
    logic                  boundary;
    logic [8:0]            v_fetch;
    logic [5:0]            tgt_idx;
    logic [2:0]            tgt_row;
    logic                  pend;
    logic                  stale;
    logic                  start;
    logic                  lo_done;
    logic                  hi_done;
    logic [7:0]            code_q;
    logic [7:0]            attr_q;
    logic [`ROM_DW-1:0]    lo_q;
    logic [2*`ROM_DW-1:0]  row_nxt;
    bank_t                 bank_nxt;
    logic                  row_ok;
    logic [2*`ROM_DW-1:0]  shifter;

    // first pixel of each tile
    assign boundary = pxl_cen && (hdump[2:0] == 3'd0);

    // column 7 fetches column 0 of the following line
    always_comb begin
        v_fetch = vdump;
        if (hdump[5:3] == 3'd7) begin
            v_fetch = (vdump == 9'(`V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    assign start   = (state == FETCH_IDLE) && pend;
    assign lo_done = (state == FETCH_LO) && rom.cs && rom.ok;
    assign hi_done = (state == FETCH_HI) && rom.cs && rom.ok;

    // cpu side of the tile map
    always_ff @(posedge clk) begin
        if (bus.cs && !bus.rnw) begin
            vram[bus.addr] <= bus.wdata;
        end
        if (bus.cs && bus.rnw) begin
            bus.rdata <= vram[bus.addr];
        end
    end

    // fetch payload, addr set a cycle before cs rises
    always_ff @(posedge clk) begin
        if (boundary) begin
            tgt_idx <= {v_fetch[5:3], hdump[5:3] + 3'd1};
            tgt_row <= v_fetch[2:0];
        end
        if (start) begin
            code_q   <= vram[{1'b0, tgt_idx}];
            attr_q   <= vram[{1'b1, tgt_idx}];
            rom.addr <= {vram[{1'b0, tgt_idx}], tgt_row, 1'b0};
        end
        if (lo_done) begin
            lo_q     <= rom.data;
            rom.addr <= {code_q, tgt_row, 1'b1};
        end
        if (hi_done) begin
            row_nxt  <= {rom.data, lo_q};
            bank_nxt <= attr_q[1:0];
        end
    end

    // request sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FETCH_IDLE;
            rom.cs <= 1'b0;
            pend   <= 1'b0;
            stale  <= 1'b0;
            row_ok <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (pend) begin
                        pend  <= 1'b0;
                        state <= FETCH_LO;
                    end
                end
                FETCH_LO: begin
                    if (!rom.cs) begin
                        rom.cs <= 1'b1;
                    end else if (rom.ok) begin
                        rom.cs <= 1'b0;
                        state  <= FETCH_HI;
                    end
                end
                FETCH_HI: begin
                    if (!rom.cs) begin
                        rom.cs <= 1'b1;
                    end else if (rom.ok) begin
                        rom.cs <= 1'b0;
                        state  <= FETCH_IDLE;
                        row_ok <= !stale;
                        stale  <= 1'b0;
                    end
                end
                default: begin
                    state  <= FETCH_IDLE;
                    rom.cs <= 1'b0;
                end
            endcase
            // new tile starts, a fetch still running belongs to the old one
            if (boundary) begin
                pend   <= 1'b1;
                row_ok <= 1'b0;
                stale  <= ((state != FETCH_IDLE) && !hi_done) || start;
            end
        end
    end

    // late row shows as pixel 0 of bank 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl  <= '0;
            bank <= '0;
        end else if (boundary) begin
            pxl  <= row_ok ? row_nxt[3:0] : '0;
            bank <= row_ok ? bank_nxt : '0;
        end else if (pxl_cen) begin
            pxl  <= shifter[3:0];
        end
    end

    // leftmost pixel in the low nibble
    always_ff @(posedge clk) begin
        if (boundary) begin
            shifter <= row_ok ? row_nxt >> 4 : '0;
        end else if (pxl_cen) begin
            shifter <= shifter >> 4;
        end
    end

    a_rom_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom.cs && !rom.ok |=> $stable(rom.addr)
    );

    a_idle_no_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == FETCH_IDLE) |-> !rom.cs
    );

endmodule

// File: rtl/video_cen.sv
`timescale 1ns/1ns

module video_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [1:0] cnt;

    // free running divider
    // pxl2 on odd counts, pxl only on 3 so both rise together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 2'd1;
            pxl2_cen <= cnt[0];
            pxl_cen  <= (cnt == 2'd3);
        end
    end

    // every pixel strobe lands on a half-pixel strobe
    a_cen_nested: assert property (
        @(posedge clk) disable iff (!rst_n)
        pxl_cen |-> pxl2_cen
    );

endmodule

// File: rtl/video_colmix.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_colmix import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       lhbl,
    input  logic       lvbl,
    input  pxl_t       pxl,
    input  bank_t      bank,
    cpu_bus_if.target  bus,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    logic [7:0]           pal [0:(1 << `PAL_AW) - 1];
    logic [5:0]           pal_idx;
    logic [15:0]          pal_word;
    rgb_t                 col_q;
    logic [`PIPE_DLY-1:0] hbl_sr;
    logic [`PIPE_DLY-1:0] vbl_sr;
    logic                 show;

    // cpu access, byte wide
    always_ff @(posedge clk) begin
        if (bus.cs && !bus.rnw) begin
            pal[bus.addr] <= bus.wdata;
        end
        if (bus.cs && bus.rnw) begin
            bus.rdata <= pal[bus.addr];
        end
    end

    // 16 colours per bank, two bytes each
    assign pal_idx  = {bank, pxl};
    // little endian pair
    assign pal_word = {pal[{pal_idx, 1'b1}], pal[{pal_idx, 1'b0}]};

    // bit 15 of the word is spare
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            col_q <= rgb_t'(pal_word[14:0]);
        end
    end

    // blanking follows the pixel path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[`PIPE_DLY-2:0], lhbl};
            vbl_sr <= {vbl_sr[`PIPE_DLY-2:0], lvbl};
        end
    end

    assign lhbl_dly = hbl_sr[`PIPE_DLY-1];
    assign lvbl_dly = vbl_sr[`PIPE_DLY-1];
    assign show     = lhbl_dly && lvbl_dly;

    // black in both blanking periods
    assign red   = show ? col_q.red : 5'd0;
    assign green = show ? col_q.green : 5'd0;
    assign blue  = show ? col_q.blue : 5'd0;

endmodule

// File: rtl/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// screen geometry in pixels and lines
`define H_TOTAL       64
`define H_ACTIVE      48
`define H_SYNC_START  52
`define H_SYNC_END    56
`define V_TOTAL       40
`define V_ACTIVE      32
`define V_SYNC_START  34
`define V_SYNC_END    36

// memory widths
`define ROM_AW        12
`define ROM_DW        16
`define VRAM_AW       7
`define PAL_AW        7
// pixel path latency, tile shifter plus colour register
`define PIPE_DLY      2

// cpu address map
`define CPU_AW        10
`define VRAM_BASE     10'h000
`define PAL_BASE      10'h100
`define CTRL_ADDR     10'h200
`define ACK_ADDR      10'h201

`endif

// File: rtl/video_if.sv
`timescale 1ns/1ns
`include "video_defs.svh"

// gfx rom port, request held until ok
interface rom_if;
    logic               cs;
    logic [`ROM_AW-1:0] addr;
    logic [`ROM_DW-1:0] data;
    logic               ok;

    modport requester (output cs, output addr, input data, input ok);
    modport memory (input cs, input addr, output data, output ok);
endinterface

// byte bus slice for one region
// addr already has the region base stripped
interface cpu_bus_if #(parameter int AW = `CPU_AW);
    logic          cs;
    logic          rnw;
    logic [AW-1:0] addr;
    logic [7:0]    wdata;
    logic [7:0]    rdata;

    modport initiator (output cs, output rnw, output addr, output wdata, input rdata);
    modport target (input cs, input rnw, input addr, input wdata, output rdata);
endinterface

// File: rtl/video_pkg.sv
package video_pkg;

    // 4bpp pixel colour out of the tile layer
    typedef logic [3:0] pxl_t;

    // palette bank from attribute bits 1:0
    typedef logic [1:0] bank_t;

    // 5:5:5 colour, red ends up in the low bits
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // tile row fetch sequence
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LO,
        FETCH_HI
    } fetch_state_e;

endpackage

// File: rtl/video_timing.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_timing import bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    cpu_bus_if.target  bus,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       irqn
);

    // offset of the ack location inside the ctrl region
    localparam logic ACK_OFS = 1'(`ACK_ADDR - `CTRL_ADDR);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    ctrl_t      ctrl;
    logic       wr;
    logic       vb_start;

    // next beam position
    always_comb begin
        h_nxt = hdump + 9'd1;
        v_nxt = vdump;
        if (hdump == 9'(`H_TOTAL - 1)) begin
            h_nxt = 9'd0;
            v_nxt = (vdump == 9'(`V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    assign wr       = bus.cs && !bus.rnw;
    // first pixel of the first blanked line
    assign vb_start = pxl_cen && (v_nxt == 9'(`V_ACTIVE)) && (h_nxt == 9'd0);

    // flags follow the new count so they line up with hdump/vdump
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            lhbl  <= h_nxt < 9'(`H_ACTIVE);
            lvbl  <= v_nxt < 9'(`V_ACTIVE);
            hs    <= (h_nxt >= 9'(`H_SYNC_START)) && (h_nxt < 9'(`H_SYNC_END));
            vs    <= (v_nxt >= 9'(`V_SYNC_START)) && (v_nxt < 9'(`V_SYNC_END));
        end
    end

    // control register and interrupt latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
            irqn <= 1'b1;
        end else begin
            if (wr && bus.addr[0] != ACK_OFS) begin
                ctrl.irq_en <= bus.wdata[0];
            end
            // ack releases the line
            if (wr && bus.addr[0] == ACK_OFS) begin
                irqn <= 1'b1;
            end
            if (vb_start && ctrl.irq_en) begin
                irqn <= 1'b0;
            end
        end
    end

    // status read, pending flag in bit 1
    always_ff @(posedge clk) begin
        if (bus.cs && bus.rnw) begin
            bus.rdata <= {6'd0, ~irqn, ctrl.irq_en};
        end
    end

    a_hdump_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        hdump < 9'(`H_TOTAL)
    );

endmodule

// File: rtl/video_top.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module video_top import bus_pkg::*, video_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_cs,
    input  logic               cpu_rnw,
    input  logic [`CPU_AW-1:0] cpu_addr,
    input  logic [7:0]         cpu_wdata,
    output logic [7:0]         cpu_rdata,
    output logic               irqn,
    output logic               rom_cs,
    output logic [`ROM_AW-1:0] rom_addr,
    input  logic [`ROM_DW-1:0] rom_data,
    input  logic               rom_ok,
    output logic               pxl2_cen,
    output logic               pxl_cen,
    output logic               lhbl,
    output logic               lvbl,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic               hs,
    output logic               vs,
    output logic [4:0]         red,
    output logic [4:0]         green,
    output logic [4:0]         blue
);

    localparam logic [`CPU_AW-1:0] VRAM_BASE_A = `VRAM_BASE;
    localparam logic [`CPU_AW-1:0] PAL_BASE_A  = `PAL_BASE;
    localparam logic [`CPU_AW-1:0] CTRL_BASE_A = `CTRL_ADDR;

    logic [8:0] hdump;
    logic [8:0] vdump;
    pxl_t       pxl;
    bank_t      bank;
    region_e    region;
    region_e    region_q;

    rom_if                      gfx_rom ();
    cpu_bus_if #(.AW(`VRAM_AW)) vram_bus ();
    cpu_bus_if #(.AW(`PAL_AW))  pal_bus ();
    cpu_bus_if #(.AW(1))        ctrl_bus ();

    // 128-byte windows for vram and palette, 2 bytes of control
    always_comb begin
        region = REG_NONE;
        if (cpu_cs) begin
            if (cpu_addr[`CPU_AW-1:7] == VRAM_BASE_A[`CPU_AW-1:7]) begin
                region = REG_VRAM;
            end else if (cpu_addr[`CPU_AW-1:7] == PAL_BASE_A[`CPU_AW-1:7]) begin
                region = REG_PAL;
            end else if (cpu_addr[`CPU_AW-1:1] == CTRL_BASE_A[`CPU_AW-1:1]) begin
                region = REG_CTRL;
            end
        end
    end

    // region offsets only
    assign vram_bus.cs    = (region == REG_VRAM);
    assign vram_bus.rnw   = cpu_rnw;
    assign vram_bus.addr  = cpu_addr[`VRAM_AW-1:0];
    assign vram_bus.wdata = cpu_wdata;
    assign pal_bus.cs     = (region == REG_PAL);
    assign pal_bus.rnw    = cpu_rnw;
    assign pal_bus.addr   = cpu_addr[`PAL_AW-1:0];
    assign pal_bus.wdata  = cpu_wdata;
    assign ctrl_bus.cs    = (region == REG_CTRL);
    assign ctrl_bus.rnw   = cpu_rnw;
    assign ctrl_bus.addr  = cpu_addr[0];
    assign ctrl_bus.wdata = cpu_wdata;

    // read data lags a clock, so the mux does too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            region_q <= REG_NONE;
        end else begin
            region_q <= (cpu_cs && cpu_rnw) ? region : REG_NONE;
        end
    end

    always_comb begin
        case (region_q)
            REG_VRAM: cpu_rdata = vram_bus.rdata;
            REG_PAL:  cpu_rdata = pal_bus.rdata;
            REG_CTRL: cpu_rdata = ctrl_bus.rdata;
            default:  cpu_rdata = 8'hff;
        endcase
    end

    // external gfx rom
    assign rom_cs       = gfx_rom.cs;
    assign rom_addr     = gfx_rom.addr;
    assign gfx_rom.data = rom_data;
    assign gfx_rom.ok   = rom_ok;

    video_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    video_timing u_timing (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .bus     ( ctrl_bus ),
        .hdump   ( hdump    ),
        .vdump   ( vdump    ),
        .lhbl    ( lhbl     ),
        .lvbl    ( lvbl     ),
        .hs      ( hs       ),
        .vs      ( vs       ),
        .irqn    ( irqn     )
    );

    tile_gfx u_tiles (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .hdump   ( hdump    ),
        .vdump   ( vdump    ),
        .bus     ( vram_bus ),
        .rom     ( gfx_rom  ),
        .pxl     ( pxl      ),
        .bank    ( bank     )
    );

    video_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .pxl      ( pxl      ),
        .bank     ( bank     ),
        .bus      ( pal_bus  ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

// File: tb/tb_clk.sv
`timescale 1ns/1ns

module tb_clk #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, clear of the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: tb/tb_video.sv
`timescale 1ns/1ns
`include "video_defs.svh"

module tb_video;

    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL * 4;
    // lead-in to the first vs pulse, three frames after it and some headroom
    localparam int MAX_CYCLES = `V_SYNC_START * `H_TOTAL * 4 + 3 * FRAME_CLKS + 576;
    localparam int NUM_PIX    = `H_ACTIVE * `V_ACTIVE;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic               clk;
    logic               rst_n;
    logic               cpu_cs;
    logic               cpu_rnw;
    logic [`CPU_AW-1:0] cpu_addr;
    logic [7:0]         cpu_wdata;
    logic [7:0]         cpu_rdata;
    logic               irqn;
    logic               rom_cs;
    logic [`ROM_AW-1:0] rom_addr;
    logic [`ROM_DW-1:0] rom_data;
    logic               rom_ok;
    logic               pxl2_cen;
    logic               pxl_cen;
    logic               lhbl;
    logic               lvbl;
    logic               lhbl_dly;
    logic               lvbl_dly;
    logic               hs;
    logic               vs;
    logic [4:0]         red;
    logic [4:0]         green;
    logic [4:0]         blue;

    // reference copies of every memory
    logic [`ROM_DW-1:0] rom_mem [0:(1 << `ROM_AW) - 1];
    logic [1:0]         lat_tab [0:255];
    logic [7:0]         vram_m [0:127];
    logic [7:0]         pal_m [0:127];
    logic [31:0]        lfsr;
    logic [7:0]         req_cnt;
    logic [14:0]        exp_rgb;
    logic               pic_on;
    logic               hs_prev;
    logic               vs_prev;
    logic               hs_seen;
    logic               vs_seen;
    logic               hbl_prev;
    logic               vbl_prev;
    logic               p2_prev;
    logic               p2_seen;
    logic               cen_seen;
    int                 cen_gap;
    int                 hs_cnt;
    int                 vs_cnt;
    int                 px_x;
    int                 px_y;
    int                 pix_checks;
    int                 cycles;
    int                 err_reset;
    int                 err_bus;
    int                 err_irq;
    int                 err_run;
    int                 err_sync;
    int                 err_pix;

    tb_clk u_clk (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    video_top u_video_top (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu_cs    ( cpu_cs    ),
        .cpu_rnw   ( cpu_rnw   ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_wdata ),
        .cpu_rdata ( cpu_rdata ),
        .irqn      ( irqn      ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    // galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // colour of visible pixel x,y straight from the layout rules
    function automatic logic [14:0] model_rgb(input int x, input int y);
        int          idx;
        int          pi;
        logic [7:0]  code;
        logic [1:0]  bnk;
        logic [15:0] word;
        logic [3:0]  pix;
        logic [15:0] col;
        idx  = (y / 8) * 8 + x / 8;
        code = vram_m[7'(idx)];
        bnk  = vram_m[7'(64 + idx)][1:0];
        // code, row inside the tile, half
        word = rom_mem[{code, 3'(y % 8), 1'((x % 8) / 4)}];
        pix  = 4'(word >> (4 * (x % 4)));
        pi   = 16 * int'(bnk) + int'(pix);
        col  = {pal_m[7'(2 * pi + 1)], pal_m[7'(2 * pi)]};
        return col[14:0];
    endfunction

    task automatic show_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
    endtask

    task automatic bus_write(input logic [`CPU_AW-1:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge clk);
        cpu_cs  = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    // data is valid one clock after cs
    task automatic bus_read_check(input logic [`CPU_AW-1:0] addr, input logic [7:0] exp);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        cpu_cs = 1'b0;
        if (cpu_rdata !== exp) begin
            show_mismatch($sformatf("cpu_rdata at 0x%h", addr), 32'(exp), 32'(cpu_rdata));
            err_bus++;
        end
    endtask

    // optionally irqn must stay high the whole way
    task automatic wait_vs_rise(input logic irq_quiet);
        logic prev;
        logic seen;
        logic flagged;
        prev    = vs;
        seen    = 1'b0;
        flagged = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (irq_quiet && !flagged && irqn !== 1'b1) begin
                show_mismatch("irqn", 32'd1, 32'(irqn));
                err_irq++;
                flagged = 1'b1;
            end
            seen = vs && !prev;
            prev = vs;
        end
    endtask

    task automatic wait_lvbl_fall();
        logic prev;
        logic seen;
        prev = lvbl;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = prev && !lvbl;
            prev = lvbl;
        end
    endtask

    // rom side, ok after 0 to 3 clocks from the table
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        req_cnt  = '0;
        forever begin
            @(negedge clk);
            if (rom_cs && !rom_ok) begin
                repeat (lat_tab[req_cnt]) @(negedge clk);
                req_cnt++;
                rom_data = rom_mem[rom_addr];
                rom_ok   = 1'b1;
                @(negedge clk);
                rom_ok = 1'b0;
            end
        end
    end

    // syncs, blanking and picture, sampled mid clock
    initial begin
        hs_prev    = 1'b0;
        vs_prev    = 1'b0;
        hs_seen    = 1'b0;
        vs_seen    = 1'b0;
        hbl_prev   = 1'b0;
        vbl_prev   = 1'b0;
        p2_prev    = 1'b0;
        p2_seen    = 1'b0;
        cen_seen   = 1'b0;
        cen_gap    = 0;
        hs_cnt     = 0;
        vs_cnt     = 0;
        px_x       = 0;
        px_y       = 0;
        pix_checks = 0;
        err_sync   = 0;
        err_pix    = 0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                // half-pixel strobe alternates once it has started
                if (p2_seen && pxl2_cen === p2_prev) begin
                    show_mismatch("pxl2_cen", 32'(!p2_prev), 32'(pxl2_cen));
                    err_sync++;
                end
                p2_seen = p2_seen || pxl2_cen;
                p2_prev = pxl2_cen;
                cen_gap++;
                if (pxl_cen) begin
                    // both strobes high in the same clock
                    if (pxl2_cen !== 1'b1) begin
                        show_mismatch("pxl2_cen", 32'd1, 32'(pxl2_cen));
                        err_sync++;
                    end
                    if (cen_seen && cen_gap != 4) begin
                        show_mismatch("pxl_cen period", 32'd4, 32'(cen_gap));
                        err_sync++;
                    end
                    cen_seen = 1'b1;
                    cen_gap  = 0;
                end
                if (pxl_cen) begin
                    hs_cnt++;
                    vs_cnt++;
                    // x from the delayed hblank rise, y from lines since vblank rise
                    if (lhbl_dly && !hbl_prev) begin
                        px_x = 0;
                        px_y = (lvbl_dly && !vbl_prev) ? 0 : px_y + 1;
                    end else begin
                        px_x++;
                    end
                    hbl_prev = lhbl_dly;
                    vbl_prev = lvbl_dly;
                    if (lhbl_dly && lvbl_dly) begin
                        if (pic_on) begin
                            exp_rgb = model_rgb(px_x, px_y);
                            if (red !== exp_rgb[4:0]) begin
                                show_mismatch("red", 32'(exp_rgb[4:0]), 32'(red));
                                err_pix++;
                            end
                            if (green !== exp_rgb[9:5]) begin
                                show_mismatch("green", 32'(exp_rgb[9:5]), 32'(green));
                                err_pix++;
                            end
                            if (blue !== exp_rgb[14:10]) begin
                                show_mismatch("blue", 32'(exp_rgb[14:10]), 32'(blue));
                                err_pix++;
                            end
                            pix_checks++;
                        end
                    end else if ({red, green, blue} !== 15'd0) begin
                        show_mismatch("rgb in blanking", 32'd0, 32'({red, green, blue}));
                        err_pix++;
                    end
                end
                if (hs && !hs_prev) begin
                    if (hs_seen && hs_cnt != `H_TOTAL) begin
                        show_mismatch("hs period", `H_TOTAL, hs_cnt);
                        err_sync++;
                    end
                    hs_seen = 1'b1;
                    hs_cnt  = 0;
                end
                if (vs && !vs_prev) begin
                    if (vs_seen && vs_cnt != `H_TOTAL * `V_TOTAL) begin
                        show_mismatch("vs period", `H_TOTAL * `V_TOTAL, vs_cnt);
                        err_sync++;
                    end
                    vs_seen = 1'b1;
                    vs_cnt  = 0;
                end
                hs_prev = hs;
                vs_prev = vs;
            end
        end
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Failure at %0t ns: run did not end within %0d clock cycles", $time, cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int         i;
        int         total;
        logic [6:0] a;
        logic [7:0] d;
        cpu_cs    = 1'b0;
        cpu_rnw   = 1'b1;
        cpu_addr  = '0;
        cpu_wdata = '0;
        pic_on    = 1'b0;
        lfsr      = 32'h4591;
        err_reset = 0;
        err_bus   = 0;
        err_irq   = 0;
        err_run   = 0;
        // rom contents and request latencies
        for (i = 0; i < (1 << `ROM_AW); i++) begin
            rom_mem[12'(i)] = 16'(rand_bits(16));
        end
        for (i = 0; i < 256; i++) begin
            lat_tab[8'(i)] = 2'(rand_bits(2));
        end

        @(posedge rst_n);
        @(negedge clk);
        if (irqn !== 1'b1) begin
            show_mismatch("irqn", 32'd1, 32'(irqn));
            err_reset++;
        end
        if (rom_cs !== 1'b0) begin
            show_mismatch("rom_cs", 32'd0, 32'(rom_cs));
            err_reset++;
        end
        if (lhbl !== 1'b0 || lvbl !== 1'b0) begin
            show_mismatch("lhbl,lvbl", 32'd0, 32'({lhbl, lvbl}));
            err_reset++;
        end
        if ({red, green, blue} !== 15'd0) begin
            show_mismatch("rgb", 32'd0, 32'({red, green, blue}));
            err_reset++;
        end

        // fill both memories, then overwrite at random
        for (i = 0; i < 128; i++) begin
            d = 8'(rand_bits(8));
            vram_m[7'(i)] = d;
            bus_write(`VRAM_BASE + 10'(i), d);
            d = 8'(rand_bits(8));
            pal_m[7'(i)] = d;
            bus_write(`PAL_BASE + 10'(i), d);
        end
        for (i = 0; i < 64; i++) begin
            a = 7'(rand_bits(7));
            d = 8'(rand_bits(8));
            if (rand_bits(1) == 32'd1) begin
                vram_m[a] = d;
                bus_write(`VRAM_BASE + {3'd0, a}, d);
            end else begin
                pal_m[a] = d;
                bus_write(`PAL_BASE + {3'd0, a}, d);
            end
        end
        for (i = 0; i < 128; i++) begin
            bus_read_check(`VRAM_BASE + 10'(i), vram_m[7'(i)]);
            bus_read_check(`PAL_BASE + 10'(i), pal_m[7'(i)]);
        end

        // one whole frame of picture, irq_en still clear
        wait_vs_rise(1'b0);
        pic_on = 1'b1;
        wait_vs_rise(1'b1);
        pic_on = 1'b0;
        if (pix_checks != NUM_PIX) begin
            $display("Failure at %0t ns: %0d of %0d visible pixels checked",
                     $time, pix_checks, NUM_PIX);
            err_run++;
        end

        // vblank interrupt and its ack
        bus_write(`CTRL_ADDR, 8'h01);
        wait_lvbl_fall();
        if (irqn !== 1'b0) begin
            show_mismatch("irqn", 32'd0, 32'(irqn));
            err_irq++;
        end
        bus_read_check(`CTRL_ADDR, 8'h03);
        bus_write(`ACK_ADDR, 8'h00);
        if (irqn !== 1'b1) begin
            show_mismatch("irqn", 32'd1, 32'(irqn));
            err_irq++;
        end
        bus_write(`CTRL_ADDR, 8'h00);
        // rest of this frame, then a whole one through the next vblank start
        wait_vs_rise(1'b1);
        wait_vs_rise(1'b1);

        total = err_reset + err_sync + err_bus + err_pix + err_irq + err_run;
        $display("errors: reset %0d, sync %0d, cpu bus %0d, picture %0d, irq %0d, run %0d",
                 err_reset, err_sync, err_bus, err_pix, err_irq, err_run);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
